// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module mp0_tb -f vlog.f -o mp0_sim \
    > build.log 2>&1 \
    && ./obj_dir/mp0_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1 || exit 0

// ==== src/arbiter.sv ====
module arbiter (
    input  logic                  clk,
    input  logic                  i_arst_n,
    input  cache_types::mem_req_t i_ireq,
    input  cache_types::mem_req_t i_dreq,
    output cache_types::mem_rsp_t o_irsp,
    output cache_types::mem_rsp_t o_drsp,
    output cache_types::mem_req_t o_l2_req,
    input  cache_types::mem_rsp_t i_l2_rsp,
    output logic                  o_igrant,
    output logic                  o_dgrant
);
    import lc3b_types::*;
    import cache_types::*;

    logic          busy_q;
    logic          gnt_d_q;      // port that owns the l2, 1 = data
    logic          last_d_q;     // port served last
    logic          igrant_q;
    logic          dgrant_q;
    mem_op_e       req_op_q;
    lc3b_word      req_addr_q;
    lc3b_cacheline req_wdata_q;

    logic          ireq_v;
    logic          dreq_v;
    logic          take;
    logic          pick_d;
    mem_req_t      winner;

    assign ireq_v = i_ireq.op != OP_NONE;
    assign dreq_v = i_dreq.op != OP_NONE;
    assign take   = !busy_q && (ireq_v || dreq_v);

    // on a tie the port not served last wins
    assign pick_d = dreq_v && (!ireq_v || !last_d_q);
    assign winner = pick_d ? i_dreq : i_ireq;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            busy_q   <= 1'b0;
            gnt_d_q  <= 1'b0;
            last_d_q <= 1'b0;
            igrant_q <= 1'b0;
            dgrant_q <= 1'b0;
            req_op_q <= OP_NONE;
        end else begin
            igrant_q <= take && !pick_d;
            dgrant_q <= take && pick_d;
            if (take) begin
                busy_q   <= 1'b1;
                gnt_d_q  <= pick_d;
                req_op_q <= winner.op;
            end else if (busy_q && i_l2_rsp.resp) begin
                busy_q   <= 1'b0;
                last_d_q <= gnt_d_q;
                req_op_q <= OP_NONE;   // idle again next cycle
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            req_addr_q  <= winner.address;
            req_wdata_q <= winner.wdata;
        end
    end

    always_comb begin
        o_l2_req.op      = req_op_q;
        o_l2_req.address = req_addr_q;
        o_l2_req.wdata   = req_wdata_q;
    end

    // steer the l2 answer back to the granted port
    always_comb begin
        o_irsp       = i_l2_rsp;
        o_drsp       = i_l2_rsp;
        o_irsp.resp  = i_l2_rsp.resp && busy_q && !gnt_d_q;
        o_drsp.resp  = i_l2_rsp.resp && busy_q && gnt_d_q;
    end

    assign o_igrant = igrant_q;
    assign o_dgrant = dgrant_q;

    // an answer only reaches a port that still holds its request
    a_rsp_to_req: assert property (@(posedge clk) disable iff (!i_arst_n)
        !(o_irsp.resp && !ireq_v) && !(o_drsp.resp && !dreq_v));

    // the l2 only answers a request this stage placed
    a_rsp_owned: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_l2_rsp.resp |-> busy_q);

endmodule : arbiter

// ==== src/cache_defines.svh ====
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// l2 geometry, 16-byte lines in 8 direct-mapped sets
`define L2_LINE_BYTES   16
`define L2_SETS         8
`define L2_INDEX_BITS   3
`define L2_OFFSET_BITS  4
`define L2_TAG_BITS     9

// performance counter bank and slot order
`define NUM_COUNTERS    4
`define CNT_L2HIT       0
`define CNT_L2MISS      1
`define CNT_IGRANT      2
`define CNT_DGRANT      3

`endif

// ==== src/cache_types.sv ====
`include "cache_defines.svh"

package cache_types;

    // operation carried by every memory-side request
    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,
        OP_READ  = 2'd1,
        OP_WRITE = 2'd2
    } mem_op_e;

    typedef struct packed {
        mem_op_e                   op;
        lc3b_types::lc3b_word      address;  // line aligned, offset ignored
        lc3b_types::lc3b_cacheline wdata;
    } mem_req_t;

    typedef struct packed {
        logic                      resp;     // one-cycle pulse
        lc3b_types::lc3b_cacheline rdata;
    } mem_rsp_t;

    // l2 controller states
    typedef enum logic [1:0] {
        S_IDLE,
        S_WRITEBACK,
        S_ALLOCATE,
        S_RESPOND
    } l2_state_e;

    typedef lc3b_types::lc3b_word [`NUM_COUNTERS-1:0] counter_vec_t;

endpackage : cache_types

// ==== src/l2_cache.sv ====
`include "cache_defines.svh"

module l2_cache (
    input  logic                  clk,
    input  logic                  i_arst_n,
    input  cache_types::mem_req_t i_req,
    output cache_types::mem_rsp_t o_rsp,
    output cache_types::mem_req_t o_pmem_req,
    input  cache_types::mem_rsp_t i_pmem_rsp,
    output logic                  o_hit,
    output logic                  o_miss
);
    import lc3b_types::*;
    import cache_types::*;

    l2_state_e                 state_q;

    // line storage
    lc3b_cacheline             data_q [`L2_SETS];
    logic [`L2_TAG_BITS-1:0]   tag_q  [`L2_SETS];
    logic [`L2_SETS-1:0]       valid_q;
    logic [`L2_SETS-1:0]       dirty_q;

    logic [`L2_INDEX_BITS-1:0] idx;
    logic [`L2_TAG_BITS-1:0]   tag;
    logic                      req_valid;
    logic                      is_write;
    logic                      hit;
    logic                      decide;
    logic                      hit_write;
    logic                      fill_done;
    logic                      victim_dirty;

    // address split: tag | index | offset
    assign idx = i_req.address[`L2_OFFSET_BITS +: `L2_INDEX_BITS];
    assign tag = i_req.address[(`L2_OFFSET_BITS + `L2_INDEX_BITS) +: `L2_TAG_BITS];

    assign req_valid    = i_req.op != OP_NONE;
    assign is_write     = i_req.op == OP_WRITE;
    assign hit          = valid_q[idx] && (tag_q[idx] == tag);
    assign victim_dirty = valid_q[idx] && dirty_q[idx];

    // request is decided exactly once, in its single S_IDLE cycle
    assign decide    = (state_q == S_IDLE) && req_valid;
    assign hit_write = decide && hit && is_write;
    assign fill_done = (state_q == S_ALLOCATE) && i_pmem_rsp.resp;

    assign o_hit  = decide && hit;
    assign o_miss = decide && !hit;

    // controller and line status
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= S_IDLE;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (req_valid) begin
                        if (hit) begin
                            state_q <= S_RESPOND;
                            if (is_write) begin
                                dirty_q[idx] <= 1'b1;
                            end
                        end else if (victim_dirty) begin
                            state_q <= S_WRITEBACK;
                        end else begin
                            state_q <= S_ALLOCATE;
                        end
                    end
                end
                S_WRITEBACK: begin
                    if (i_pmem_rsp.resp) begin
                        dirty_q[idx] <= 1'b0;   // victim now clean in memory
                        state_q      <= S_ALLOCATE;
                    end
                end
                S_ALLOCATE: begin
                    if (i_pmem_rsp.resp) begin
                        valid_q[idx] <= 1'b1;
                        dirty_q[idx] <= is_write;   // write miss lands dirty
                        state_q      <= S_RESPOND;
                    end
                end
                S_RESPOND: begin
                    state_q <= S_IDLE;
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    // data and tag arrays
    always_ff @(posedge clk) begin
        if (hit_write) begin
            data_q[idx] <= i_req.wdata;   // whole line replaced
        end else if (fill_done) begin
            data_q[idx] <= is_write ? i_req.wdata : i_pmem_rsp.rdata;
            tag_q[idx]  <= tag;
        end
    end

    // answer to the arbiter, line is already in place by S_RESPOND
    always_comb begin
        o_rsp.resp  = state_q == S_RESPOND;
        o_rsp.rdata = data_q[idx];
    end

    // memory side
    always_comb begin
        o_pmem_req.op      = OP_NONE;
        o_pmem_req.address = {tag, idx, {`L2_OFFSET_BITS{1'b0}}};
        o_pmem_req.wdata   = data_q[idx];
        case (state_q)
            S_WRITEBACK: begin
                // victim goes back to its own address
                o_pmem_req.op      = OP_WRITE;
                o_pmem_req.address = {tag_q[idx], idx, {`L2_OFFSET_BITS{1'b0}}};
            end
            S_ALLOCATE: begin
                o_pmem_req.op = OP_READ;
            end
            default: begin
                o_pmem_req.op = OP_NONE;
            end
        endcase
    end

    a_pmem_stable: assert property (@(posedge clk) disable iff (!i_arst_n)
        (o_pmem_req.op != OP_NONE && !i_pmem_rsp.resp) |=> $stable(o_pmem_req));

    // the requester must still hold its request when answered
    a_rsp_has_req: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_rsp.resp |-> req_valid && $stable(i_req));

endmodule : l2_cache

// ==== src/lc3b_types.sv ====
package lc3b_types;

    localparam int WORD_BITS  = 16;
    localparam int LINE_WORDS = 8;                      // words per cacheline
    localparam int LINE_BITS  = WORD_BITS * LINE_WORDS;

    // byte address or data word
    typedef logic [WORD_BITS-1:0] lc3b_word;

    // whole cacheline, word 0 in the low bits
    typedef logic [LINE_BITS-1:0] lc3b_cacheline;

endpackage : lc3b_types

// ==== src/mp0.sv ====
`include "cache_defines.svh"

module mp0 (
    input  logic                      clk,
    input  logic                      i_arst_n,

    // instruction and data L1 ports
    input  cache_types::mem_req_t     i_ireq,
    output cache_types::mem_rsp_t     o_irsp,
    input  cache_types::mem_req_t     i_dreq,
    output cache_types::mem_rsp_t     o_drsp,

    // physical memory
    output cache_types::mem_req_t     o_pmem_req,
    input  cache_types::mem_rsp_t     i_pmem_rsp,

    // counter bank
    input  logic [`NUM_COUNTERS-1:0]  i_counter_clear,
    output cache_types::counter_vec_t o_counts
);
    import cache_types::*;

    mem_req_t                 l2_req;
    mem_rsp_t                 l2_rsp;
    logic                     l2_hit;
    logic                     l2_miss;
    logic                     igrant;
    logic                     dgrant;
    logic [`NUM_COUNTERS-1:0] events;

    arbiter u_arbiter (
        .clk,
        .i_arst_n,
        .i_ireq,
        .i_dreq,
        .o_irsp,
        .o_drsp,
        .o_l2_req (l2_req),
        .i_l2_rsp (l2_rsp),
        .o_igrant (igrant),
        .o_dgrant (dgrant)
    );

    l2_cache u_l2_cache (
        .clk,
        .i_arst_n,
        .i_req      (l2_req),
        .o_rsp      (l2_rsp),
        .o_pmem_req,
        .i_pmem_rsp,
        .o_hit      (l2_hit),
        .o_miss     (l2_miss)
    );

    // event slots in counter order
    assign events[`CNT_L2HIT]  = l2_hit;
    assign events[`CNT_L2MISS] = l2_miss;
    assign events[`CNT_IGRANT] = igrant;
    assign events[`CNT_DGRANT] = dgrant;

    perf_counters u_perf_counters (
        .clk,
        .i_arst_n,
        .i_inc    (events),
        .i_clear  (i_counter_clear),
        .o_counts
    );

endmodule : mp0

// ==== src/perf_counters.sv ====
`include "cache_defines.svh"

module perf_counters (
    input  logic                      clk,
    input  logic                      i_arst_n,
    input  logic [`NUM_COUNTERS-1:0]  i_inc,
    input  logic [`NUM_COUNTERS-1:0]  i_clear,
    output cache_types::counter_vec_t o_counts
);
    import cache_types::*;

    counter_vec_t counts_q;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            counts_q <= '0;
        end else begin
            for (int i = 0; i < `NUM_COUNTERS; i++) begin
                if (i_clear[i]) begin
                    counts_q[i] <= '0;   // clear beats increment
                end else if (i_inc[i] && (counts_q[i] != 16'hFFFF)) begin
                    counts_q[i] <= counts_q[i] + 16'd1;
                end
            end
        end
    end

    assign o_counts = counts_q;

endmodule : perf_counters

// ==== tests/mp0_tb.sv ====
`include "cache_defines.svh"

module mp0_tb;
    import lc3b_types::*;
    import cache_types::*;

    logic                     clk;
    logic                     arst_n;
    mem_req_t                 ireq;
    mem_req_t                 dreq;
    mem_rsp_t                 irsp;
    mem_rsp_t                 drsp;
    mem_req_t                 pmem_req;
    mem_rsp_t                 pmem_rsp;
    logic [`NUM_COUNTERS-1:0] clear;
    counter_vec_t             counts;

    // architectural line contents and a mirror of the l2 status
    lc3b_cacheline            golden [lc3b_word];
    logic [`L2_TAG_BITS-1:0]  tag_m [`L2_SETS];
    logic [`L2_SETS-1:0]      valid_m;
    logic [`L2_SETS-1:0]      dirty_m;
    lc3b_word                 exp_cnt [`NUM_COUNTERS];

    mem_req_t                 iq [$];
    mem_req_t                 dq [$];
    int                       resp_cnt [2];   // 0 = instruction, 1 = data
    int                       resp_used [2];
    int                       waits [2];
    bit                       wb_seen;
    lc3b_word                 wb_addr_seen;
    lc3b_cacheline            wb_data_seen;
    int                       n_checks;
    int                       n_errors;

    mp0 u_dut (
        .clk             (clk),
        .i_arst_n        (arst_n),
        .i_ireq          (ireq),
        .o_irsp          (irsp),
        .i_dreq          (dreq),
        .o_drsp          (drsp),
        .o_pmem_req      (pmem_req),
        .i_pmem_rsp      (pmem_rsp),
        .i_counter_clear (clear),
        .o_counts        (counts)
    );

    pmem_model u_pmem (
        .clk      (clk),
        .i_arst_n (arst_n),
        .i_req    (pmem_req),
        .o_rsp    (pmem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic mem_req_t make_req(input mem_op_e op, input lc3b_word addr,
                                          input lc3b_cacheline data);
        mem_req_t req;
        req.op      = op;
        req.address = addr;
        req.wdata   = data;
        return req;
    endfunction

    function automatic mem_req_t rand_req();
        lc3b_word      addr;
        lc3b_cacheline data;
        addr = {7'd0, 2'($urandom_range(3, 0)), 3'($urandom_range(7, 0)),
                4'($urandom_range(15, 0))};   // few tags so sets collide
        data = {$urandom, $urandom, $urandom, $urandom};
        return make_req(($urandom_range(1, 0) == 0) ? OP_READ : OP_WRITE, addr, data);
    endfunction

    function automatic lc3b_cacheline golden_line(input lc3b_word line_addr);
        lc3b_cacheline line;
        if (golden.exists(line_addr)) begin
            return golden[line_addr];
        end
        for (int w = 0; w < LINE_WORDS; w++) begin
            line[w*WORD_BITS +: WORD_BITS] = line_addr + lc3b_word'(w);
        end
        return line;
    endfunction

    // expected rdata, hit, and victim of a dirty write-back
    function automatic logic predict(input mem_req_t req, output lc3b_cacheline exp_rdata,
                                     output logic exp_wb, output lc3b_word wb_addr,
                                     output lc3b_cacheline wb_line);
        logic [`L2_INDEX_BITS-1:0] idx;
        logic [`L2_TAG_BITS-1:0]   tag;
        logic                      hit;
        idx       = req.address[`L2_OFFSET_BITS +: `L2_INDEX_BITS];
        tag       = req.address[15 -: `L2_TAG_BITS];
        hit       = valid_m[idx] && (tag_m[idx] == tag);
        exp_wb    = !hit && valid_m[idx] && dirty_m[idx];
        wb_addr   = {tag_m[idx], idx, 4'h0};
        wb_line   = golden_line(wb_addr);
        exp_rdata = (req.op == OP_WRITE) ? req.wdata : golden_line({tag, idx, 4'h0});
        return hit;
    endfunction

    task automatic update_model(input mem_req_t req, input logic hit);
        logic [`L2_INDEX_BITS-1:0] idx;
        logic [`L2_TAG_BITS-1:0]   tag;
        logic                      wr;
        idx = req.address[`L2_OFFSET_BITS +: `L2_INDEX_BITS];
        tag = req.address[15 -: `L2_TAG_BITS];
        wr  = req.op == OP_WRITE;
        if (wr) begin
            golden[{tag, idx, 4'h0}] = req.wdata;
        end
        dirty_m[idx] = hit ? (dirty_m[idx] || wr) : wr;
        valid_m[idx] = 1'b1;
        tag_m[idx]   = tag;
    endtask

    task automatic check_true(input logic cond, input string what);
        n_checks++;
        assert (cond) else begin
            n_errors++;
            $display("%s at time %0t", what, $time);
        end
    endtask

    task automatic check_value(input string name, input lc3b_cacheline got,
                               input lc3b_cacheline exp);
        n_checks++;
        assert (got == exp) else begin
            n_errors++;
            $display("ERROR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_counts();
        for (int k = 0; k < `NUM_COUNTERS; k++) begin
            check_value($sformatf("o_counts[%0d]", k), lc3b_cacheline'(counts[k]),
                        lc3b_cacheline'(exp_cnt[k]));
        end
    endtask

    task automatic compare_resp(input mem_req_t req, input mem_rsp_t rsp, input int port);
        lc3b_cacheline exp_rdata;
        lc3b_cacheline wb_line;
        lc3b_word      wb_addr;
        logic          exp_wb;
        logic          hit;
        mem_req_t      other;
        hit   = predict(req, exp_rdata, exp_wb, wb_addr, wb_line);
        other = (port == 0) ? dreq : ireq;
        if (req.op == OP_READ) begin
            check_value((port == 0) ? "o_irsp.rdata" : "o_drsp.rdata", rsp.rdata, exp_rdata);
        end
        check_true(wb_seen == exp_wb, exp_wb ? "dirty victim was not written back"
                                             : "memory write without a dirty victim");
        if (exp_wb && wb_seen) begin
            check_value("o_pmem_req.address", lc3b_cacheline'(wb_addr_seen),
                        lc3b_cacheline'(wb_addr));
            check_value("o_pmem_req.wdata", wb_data_seen, wb_line);
        end
        wb_seen = 1'b0;
        update_model(req, hit);
        if (hit) exp_cnt[`CNT_L2HIT] = exp_cnt[`CNT_L2HIT] + 16'd1;
        else exp_cnt[`CNT_L2MISS] = exp_cnt[`CNT_L2MISS] + 16'd1;
        if (port == 0) exp_cnt[`CNT_IGRANT] = exp_cnt[`CNT_IGRANT] + 16'd1;
        else exp_cnt[`CNT_DGRANT] = exp_cnt[`CNT_DGRANT] + 16'd1;
        waits[port] = 0;
        if (other.op != OP_NONE) begin
            waits[1-port]++;
            check_true(waits[1-port] <= 2, "a port waited through more than two responses");
        end
    endtask

    // compares every response and every memory write
    always @(negedge clk) begin
        if (arst_n) begin
            if (pmem_rsp.resp && pmem_req.op == OP_WRITE) begin
                check_true(!wb_seen, "second memory write within one request");
                wb_seen      = 1'b1;
                wb_addr_seen = pmem_req.address;
                wb_data_seen = pmem_req.wdata;
            end
            if (irsp.resp) begin
                compare_resp(ireq, irsp, 0);
                resp_cnt[0]++;
            end
            if (drsp.resp) begin
                compare_resp(dreq, drsp, 1);
                resp_cnt[1]++;
            end
        end
    end

    task automatic finish_run();
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    function automatic logic pending();
        return iq.size() > 0 || dq.size() > 0 || ireq.op != OP_NONE || dreq.op != OP_NONE;
    endfunction

    // each port holds its request until answered, then takes the next one
    task automatic drain_ports(input int limit);
        int cycles;
        cycles = 0;
        while (pending() && cycles < limit) begin
            @(posedge clk);
            #2;
            if (ireq.op == OP_NONE || resp_cnt[0] != resp_used[0]) begin
                resp_used[0] = resp_cnt[0];
                ireq = make_req(OP_NONE, 16'h0000, '0);
                if (iq.size() > 0) ireq = iq.pop_front();
            end
            if (dreq.op == OP_NONE || resp_cnt[1] != resp_used[1]) begin
                resp_used[1] = resp_cnt[1];
                dreq = make_req(OP_NONE, 16'h0000, '0);
                if (dq.size() > 0) dreq = dq.pop_front();
            end
            cycles++;
        end
        if (pending()) begin
            n_errors++;
            $display("timeout with requests still pending after %0d cycles", limit);
            finish_run();
        end
    endtask

    initial begin
        lc3b_cacheline wline;
        void'($urandom(32'h4cc04d19));
        arst_n  = 1'b0;
        ireq    = make_req(OP_NONE, 16'h0000, '0);
        dreq    = make_req(OP_NONE, 16'h0000, '0);
        clear   = '0;
        valid_m = '0;
        dirty_m = '0;
        for (int k = 0; k < `NUM_COUNTERS; k++) exp_cnt[k] = '0;
        repeat (4) @(posedge clk);
        #2;
        arst_n = 1'b1;
        @(negedge clk);
        check_true(!irsp.resp && !drsp.resp && pmem_req.op == OP_NONE,
                   "outputs not idle after reset");
        check_counts();

        // never written lines on both ports
        iq.push_back(make_req(OP_READ, 16'h0000, '0));
        iq.push_back(make_req(OP_READ, 16'h0120, '0));
        dq.push_back(make_req(OP_READ, 16'h0010, '0));
        dq.push_back(make_req(OP_READ, 16'h0a20, '0));
        drain_ports(400);

        // data write seen by the instruction port, before and after eviction
        wline = {$urandom, $urandom, $urandom, $urandom};
        dq.push_back(make_req(OP_WRITE, 16'h0030, wline));
        drain_ports(200);
        iq.push_back(make_req(OP_READ, 16'h0030, '0));
        drain_ports(200);
        dq.push_back(make_req(OP_READ, 16'h01b0, '0));   // same set, other tag
        drain_ports(200);
        iq.push_back(make_req(OP_READ, 16'h0030, '0));
        drain_ports(200);

        // dirty and clean victims
        dq.push_back(make_req(OP_WRITE, 16'h0050, {$urandom, $urandom, $urandom, $urandom}));
        dq.push_back(make_req(OP_WRITE, 16'h00d0, {$urandom, $urandom, $urandom, $urandom}));
        dq.push_back(make_req(OP_READ, 16'h0150, '0));
        iq.push_back(make_req(OP_READ, 16'h0060, '0));
        iq.push_back(make_req(OP_READ, 16'h00e0, '0));
        drain_ports(800);

        // both ports busy at once
        for (int n = 0; n < 40; n++) begin
            iq.push_back(rand_req());
            dq.push_back(rand_req());
        end
        drain_ports(20000);
        check_counts();

        // clear hit and instruction grant counters only
        @(posedge clk);
        #2;
        clear[`CNT_L2HIT]  = 1'b1;
        clear[`CNT_IGRANT] = 1'b1;
        @(posedge clk);
        #2;
        clear = '0;
        exp_cnt[`CNT_L2HIT]  = '0;
        exp_cnt[`CNT_IGRANT] = '0;
        @(negedge clk);
        check_counts();
        finish_run();
    end

endmodule : mp0_tb

// ==== tests/pmem_model.sv ====
module pmem_model (
    input  logic                  clk,
    input  logic                  i_arst_n,
    input  cache_types::mem_req_t i_req,
    output cache_types::mem_rsp_t o_rsp
);
    import lc3b_types::*;
    import cache_types::*;

    lc3b_cacheline store [lc3b_word];   // lines written so far
    logic          busy_q;
    logic [1:0]    wait_q;
    logic          resp_q;
    lc3b_cacheline rdata_q;
    lc3b_word      line_addr;

    assign line_addr = {i_req.address[15:4], 4'h0};

    // untouched lines hold line address plus word index
    function automatic lc3b_cacheline fresh_line(input lc3b_word addr);
        lc3b_cacheline line;
        for (int w = 0; w < LINE_WORDS; w++) begin
            line[w*WORD_BITS +: WORD_BITS] = addr + lc3b_word'(w);
        end
        return line;
    endfunction

    always @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            busy_q  <= 1'b0;
            wait_q  <= 2'd0;
            resp_q  <= 1'b0;
            rdata_q <= '0;
        end else begin
            resp_q <= 1'b0;
            if (resp_q) begin
                busy_q <= 1'b0;   // request retires with this pulse
            end else if (i_req.op != OP_NONE) begin
                if (!busy_q) begin
                    busy_q <= 1'b1;
                    wait_q <= 2'($urandom_range(3, 0));   // 1 to 4 cycles
                end else if (wait_q != 2'd0) begin
                    wait_q <= wait_q - 2'd1;
                end else begin
                    resp_q <= 1'b1;
                    if (i_req.op == OP_WRITE) begin
                        store[line_addr] = i_req.wdata;
                        rdata_q <= i_req.wdata;
                    end else if (store.exists(line_addr)) begin
                        rdata_q <= store[line_addr];
                    end else begin
                        rdata_q <= fresh_line(line_addr);
                    end
                end
            end
        end
    end

    assign o_rsp.resp  = resp_q;
    assign o_rsp.rdata = rdata_q;

endmodule : pmem_model

// ==== vlog.f ====
+incdir+src
src/lc3b_types.sv
src/cache_types.sv
src/arbiter.sv
src/l2_cache.sv
src/perf_counters.sv
src/mp0.sv
tests/pmem_model.sv
tests/mp0_tb.sv
